// File: all.f
logic/fusion_pkg.sv
logic/set_controller.sv
logic/brick_config.sv
logic/brick_array.sv
logic/output_accumulator.sv
logic/fusion_sequencer_top.sv
test/sram_model.sv
test/tb_fusion_sequencer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fusion sequencer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns -f all.f \
    --top-module tb_fusion_sequencer --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log && exit 0 || exit 1

// File: test/tb_fusion_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fusion_sequencer
    import fusion_pkg::*;
();

    localparam int NUM_SETS     = 10;
    localparam int NUM_PROGRAMS = 5;

    // One set of a program
    typedef struct packed {
        logic [2:0] program_id;
        logic [7:0] m;
        precision_e prec;
        logic [3:0] k;
    } set_desc_t;

    // Programs 0 to 4 cover narrow lanes, fused 8-bit, long K, an empty set and a restart
    set_desc_t set_table [NUM_SETS] = '{
        '{3'd0, 8'd4, PREC_2, 4'd1},
        '{3'd0, 8'd4, PREC_4, 4'd1},
        '{3'd1, 8'd6, PREC_8, 4'd1},
        '{3'd2, 8'd3, PREC_8, 4'd15},
        '{3'd2, 8'd2, PREC_4, 4'd7},
        '{3'd3, 8'd2, PREC_8, 4'd3},
        '{3'd3, 8'd0, PREC_4, 4'd2},
        '{3'd3, 8'd3, PREC_2, 4'd2},
        '{3'd3, 8'd1, PREC_4, 4'd5},
        '{3'd4, 8'd2, PREC_2, 4'd4}
    };

    logic   clock = 1'b0;
    logic   reset;
    logic   go_i;
    word_t  input_word;
    word_t  weight_word;
    addr_t  input_addr;
    addr_t  weight_addr;
    addr_t  out_addr;
    word_t  out_data;
    logic   out_write;
    logic   finish;

    integer seed;
    int     cycle_count = 0;
    int     cycle_limit = 1000000;
    int     write_count;
    int     total_outputs;
    word_t  exp_data_q [$];

    always #4 clock = ~clock;

    sram_model input_sram (
        .clock  (clock),
        .addr_i (input_addr),
        .data_o (input_word)
    );

    sram_model weight_sram (
        .clock  (clock),
        .addr_i (weight_addr),
        .data_o (weight_word)
    );

    fusion_sequencer_top fusion_sequencer_top_inst (
        .clock         (clock),
        .reset         (reset),
        .go_i          (go_i),
        .input_word_i  (input_word),
        .weight_word_i (weight_word),
        .input_addr_o  (input_addr),
        .weight_addr_o (weight_addr),
        .out_addr_o    (out_addr),
        .out_data_o    (out_data),
        .out_write_o   (out_write),
        .finish_o      (finish)
    );

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected)
        begin
            $display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, expected);
            stop_run();
        end
    endtask

    // Signed dot product of all lanes of one word pair
    function automatic int lane_dot(input word_t a, input word_t b, input precision_e prec);
        int width;
        int av;
        int bv;
        int sum;
        width = (prec == PREC_2) ? 2 : ((prec == PREC_4) ? 4 : 8);
        sum = 0;
        for (int i = 0; i < WORD_W / width; i++)
        begin
            av = (int'(a) >> (i * width)) & ((1 << width) - 1);
            bv = (int'(b) >> (i * width)) & ((1 << width) - 1);
            if (av >= (1 << (width - 1)))
                av = av - (1 << width);
            if (bv >= (1 << (width - 1)))
                bv = bv - (1 << width);
            sum = sum + av * bv;
        end
        return sum;
    endfunction

    function automatic int cycle_budget();
        int total;
        total = 50 + 10 * NUM_PROGRAMS;
        for (int s = 0; s < NUM_SETS; s++)
            total = total + 2 + int'(set_table[s].m) * int'(set_table[s].k);
        return total;
    endfunction

    task automatic fill_memories();
        for (int a = 0; a < (1 << ADDR_W); a++)
        begin
            input_sram.mem[addr_t'(a)]  = {4'hC, addr_t'(a)};
            weight_sram.mem[addr_t'(a)] = {4'h3, ~addr_t'(a)};
        end
    endtask

    // Writes one program into both memories and queues its expected outputs
    task automatic load_program(input int prog);
        addr_t      addr;
        word_t      in_w;
        word_t      wt_w;
        int         acc;
        precision_e prec;
        fill_memories();
        exp_data_q.delete();
        write_count   = 0;
        total_outputs = 0;
        addr = '0;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            if (int'(set_table[s].program_id) == prog)
            begin
                prec = set_table[s].prec;
                input_sram.mem[addr]      = {8'h00, set_table[s].m};
                input_sram.mem[addr + 1'b1] = {4'h0, set_table[s].k, 4'h0, prec};
                addr = addr + 2'd2;
                for (int o = 0; o < int'(set_table[s].m); o++)
                begin
                    acc = 0;
                    for (int w = 0; w < int'(set_table[s].k); w++)
                    begin
                        in_w = word_t'($random(seed));
                        wt_w = word_t'($random(seed));
                        // Extreme byte values, and a sum that wraps when K is large
                        if (prec == PREC_8 && o == 0)
                        begin
                            in_w = 16'h8080;
                            wt_w = 16'h8080;
                        end
                        else if (prec == PREC_8 && o == 1 && w == 0)
                        begin
                            in_w = 16'h7F80;
                            wt_w = 16'h7F7F;
                        end
                        input_sram.mem[addr]  = in_w;
                        weight_sram.mem[addr] = wt_w;
                        addr = addr + 1'b1;
                        acc  = acc + lane_dot(in_w, wt_w, prec);
                    end
                    exp_data_q.push_back(word_t'(acc));
                end
                total_outputs = total_outputs + int'(set_table[s].m);
            end
        end
        input_sram.mem[addr]        = {8'h00, END_MARK};
        input_sram.mem[addr + 1'b1] = '0;
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // Every write is matched against the expected queue in order
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (out_write)
            begin
                if (exp_data_q.size() == 0)
                begin
                    $display("Error at %0t ns: out_write_o pulsed with no output left", $time);
                    stop_run();
                end
                else
                begin
                    check_addr("out_addr_o", out_addr, addr_t'(write_count));
                    check_word("out_data_o", out_data, exp_data_q.pop_front());
                    write_count = write_count + 1;
                end
            end
        end
    end

    initial
    begin
        seed        = 73;
        reset       = 1'b1;
        go_i        = 1'b0;
        cycle_limit = cycle_budget();
        fill_memories();

        @(posedge clock);
        @(negedge clock);
        check_flag("out_write_o", out_write, 1'b0);
        check_flag("finish_o", finish, 1'b0);
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("out_write_o", out_write, 1'b0);
        check_flag("finish_o", finish, 1'b0);
        check_addr("input_addr_o", input_addr, '0);
        check_addr("weight_addr_o", weight_addr, '0);

        for (int p = 0; p < NUM_PROGRAMS; p++)
        begin
            load_program(p);
            @(posedge clock);
            go_i <= 1'b1;
            while (finish !== 1'b1)
                @(negedge clock);
            // The final output drains out of the pipeline just after finish
            repeat (5) @(negedge clock);
            if (exp_data_q.size() != 0)
            begin
                $display("Error: %0d expected outputs were never written", exp_data_q.size());
                stop_run();
            end
            check_addr("out_addr_o", out_addr, addr_t'(total_outputs));
            check_flag("finish_o", finish, 1'b1);
            @(posedge clock);
            go_i <= 1'b0;
            repeat (2) @(negedge clock);
            check_flag("finish_o", finish, 1'b0);
            check_flag("out_write_o", out_write, 1'b0);
            check_addr("input_addr_o", input_addr, '0);
            check_addr("weight_addr_o", weight_addr, '0);
        end

        repeat (3) @(negedge clock);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model
    import fusion_pkg::*;
(
    input  logic  clock,
    input  addr_t addr_i,
    output word_t data_o
);

    // Contents are written by the testbench between runs
    word_t mem [0:(1 << ADDR_W) - 1];
    word_t data_q = '0;

    // Read data appears one cycle after the address
    always @(posedge clock)
    begin
        data_q <= mem[addr_i];
    end

    assign data_o = data_q;

endmodule

`default_nettype wire

// File: logic/fusion_sequencer_top.sv
`timescale 1ns/1ns
`default_nettype none

module fusion_sequencer_top
    import fusion_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  go_i,
    input  word_t input_word_i,
    input  word_t weight_word_i,
    output addr_t input_addr_o,
    output addr_t weight_addr_o,
    output addr_t out_addr_o,
    output word_t out_data_o,
    output logic  out_write_o,
    output logic  finish_o
);

    addr_t             read_addr;
    logic              cfg_load;
    logic              run_start;
    word_tag_t         word_tag;
    word_tag_t         prod_tag;
    brick_ctrl_array_t brick_ctrl;
    product_array_t    products;

    // Both SRAMs are read in lockstep
    assign input_addr_o  = read_addr;
    assign weight_addr_o = read_addr;

    set_controller set_controller_inst (
        .clock        (clock),
        .reset        (reset),
        .go_i         (go_i),
        .input_word_i (input_word_i),
        .read_addr_o  (read_addr),
        .cfg_load_o   (cfg_load),
        .word_tag_o   (word_tag),
        .run_start_o  (run_start),
        .finish_o     (finish_o)
    );

    brick_config brick_config_inst (
        .clock        (clock),
        .reset        (reset),
        .cfg_load_i   (cfg_load),
        .input_word_i (input_word_i),
        .brick_ctrl_o (brick_ctrl)
    );

    brick_array brick_array_inst (
        .clock         (clock),
        .reset         (reset),
        .brick_ctrl_i  (brick_ctrl),
        .input_word_i  (input_word_i),
        .weight_word_i (weight_word_i),
        .tag_i         (word_tag),
        .products_o    (products),
        .tag_o         (prod_tag)
    );

    output_accumulator output_accumulator_inst (
        .clock       (clock),
        .reset       (reset),
        .run_start_i (run_start),
        .products_i  (products),
        .tag_i       (prod_tag),
        .out_addr_o  (out_addr_o),
        .out_data_o  (out_data_o),
        .out_write_o (out_write_o)
    );

endmodule

`default_nettype wire

// File: logic/output_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module output_accumulator
    import fusion_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           run_start_i,
    input  product_array_t products_i,
    input  word_tag_t      tag_i,
    output addr_t          out_addr_o,
    output word_t          out_data_o,
    output logic           out_write_o
);

    word_t lane_sum;
    word_t acc_q;
    word_t data_q;
    addr_t addr_q;
    logic  write_q;

    // Sum wraps modulo 2^16
    always_comb
    begin
        lane_sum = '0;
        for (int i = 0; i < NUM_BRICKS; i++)
            lane_sum = lane_sum + word_t'(products_i[i]);
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            acc_q   <= '0;
            addr_q  <= '0;
            write_q <= 1'b0;
        end
        else
        begin
            write_q <= tag_i.valid && tag_i.last;
            if (run_start_i)
                acc_q <= '0;
            else if (tag_i.valid && tag_i.last)
                acc_q <= '0;
            else if (tag_i.valid)
                acc_q <= acc_q + lane_sum;
            // Address moves on once the current write is done
            if (run_start_i)
                addr_q <= '0;
            else if (write_q)
                addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (tag_i.valid && tag_i.last)
            data_q <= acc_q + lane_sum;
    end

    assign out_addr_o  = addr_q;
    assign out_data_o  = data_q;
    assign out_write_o = write_q;

    // A last tag only ever comes with a valid word
    a_last_is_valid: assert property (@(posedge clock) disable iff (reset)
        tag_i.last |-> tag_i.valid);

endmodule

`default_nettype wire

// File: logic/brick_array.sv
`timescale 1ns/1ns
`default_nettype none

module brick_array
    import fusion_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  brick_ctrl_array_t brick_ctrl_i,
    input  word_t             input_word_i,
    input  word_t             weight_word_i,
    input  word_tag_t         tag_i,
    output product_array_t    products_o,
    output word_tag_t         tag_o
);

    product_array_t prod_q;
    product_array_t shift_q;
    word_tag_t      tag1_q;
    word_tag_t      tag2_q;

    // Picks a 2-bit lane or a 4-bit nibble and extends it to brick width
    function automatic logic signed [BRICK_W-1:0] slice_operand(
        input word_t      word,
        input precision_e prec,
        input logic       byte_sel,
        input logic [1:0] slice,
        input logic       sign_ext
    );
        logic [3:0] nibble;
        logic [1:0] lane;
        nibble = word[{slice, 2'b00} +: 4];
        lane   = word[{byte_sel, slice, 1'b0} +: 2];
        if (prec == PREC_2)
            return {{(BRICK_W-2){sign_ext & lane[1]}}, lane};
        else
            return {sign_ext & nibble[3], nibble};
    endfunction

    for (genvar i = 0; i < NUM_BRICKS; i++)
    begin : g_brick
        localparam bit BYTE_SEL = (i >= NUM_BRICKS / 2);

        brick_ctrl_t                 ctrl;
        logic signed [BRICK_W-1:0]   in_op;
        logic signed [BRICK_W-1:0]   w_op;
        logic signed [2*BRICK_W-1:0] mult;

        assign ctrl  = brick_ctrl_i.bricks[i];
        assign in_op = slice_operand(input_word_i, brick_ctrl_i.precision, BYTE_SEL,
                                     ctrl.in_slice, ctrl.in_signed);
        assign w_op  = slice_operand(weight_word_i, brick_ctrl_i.precision, BYTE_SEL,
                                     ctrl.w_slice, ctrl.w_signed);
        assign mult  = in_op * w_op;

        always_ff @(posedge clock)
        begin
            // Products stage
            if (ctrl.enable)
                prod_q[i] <= {{(PROD_W-2*BRICK_W){mult[2*BRICK_W-1]}}, mult};
            else
                prod_q[i] <= '0;
            // Shift stage places fused 8-bit partials at 0, 4 or 8
            shift_q[i] <= prod_q[i] << ctrl.shift;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            tag1_q <= '0;
            tag2_q <= '0;
        end
        else
        begin
            tag1_q <= tag_i;
            tag2_q <= tag1_q;
        end
    end

    assign products_o = shift_q;
    assign tag_o      = tag2_q;

endmodule

`default_nettype wire

// File: logic/brick_config.sv
`timescale 1ns/1ns
`default_nettype none

module brick_config
    import fusion_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              cfg_load_i,
    input  word_t             input_word_i,
    output brick_ctrl_array_t brick_ctrl_o
);

    precision_e prec_q;
    logic [1:0] pair;

    always_ff @(posedge clock)
    begin
        if (reset)
            prec_q <= PREC_2;
        else if (cfg_load_i)
            prec_q <= precision_e'(input_word_i[3:0]);
    end

    always_comb
    begin
        brick_ctrl_o.precision = prec_q;
        pair = 2'b00;
        for (int i = 0; i < NUM_BRICKS; i++)
        begin
            brick_ctrl_o.bricks[i] = '0;
            pair = i[1:0];
            case (prec_q)
                PREC_2:
                begin
                    // Lane index within the brick's byte
                    brick_ctrl_o.bricks[i].enable    = 1'b1;
                    brick_ctrl_o.bricks[i].in_slice  = pair;
                    brick_ctrl_o.bricks[i].w_slice   = pair;
                    brick_ctrl_o.bricks[i].in_signed = 1'b1;
                    brick_ctrl_o.bricks[i].w_signed  = 1'b1;
                end
                PREC_4:
                begin
                    brick_ctrl_o.bricks[i].enable    = (i < NUM_BRICKS / 2);
                    brick_ctrl_o.bricks[i].in_slice  = pair;
                    brick_ctrl_o.bricks[i].w_slice   = pair;
                    brick_ctrl_o.bricks[i].in_signed = 1'b1;
                    brick_ctrl_o.bricks[i].w_signed  = 1'b1;
                end
                PREC_8:
                begin
                    // Pair bit 1 picks the input high nibble, bit 0 the weight high nibble
                    brick_ctrl_o.bricks[i].enable    = 1'b1;
                    brick_ctrl_o.bricks[i].in_slice  = {i[2], pair[1]};
                    brick_ctrl_o.bricks[i].w_slice   = {i[2], pair[0]};
                    brick_ctrl_o.bricks[i].in_signed = pair[1];
                    brick_ctrl_o.bricks[i].w_signed  = pair[0];
                    brick_ctrl_o.bricks[i].shift     = {pair[1] & pair[0], pair[1] ^ pair[0], 2'b00};
                end
                default:
                begin
                    brick_ctrl_o.bricks[i].enable = 1'b0;
                end
            endcase
        end
    end

    a_prec_legal: assert property (@(posedge clock) disable iff (reset)
        cfg_load_i |=> prec_q inside {PREC_2, PREC_4, PREC_8});

endmodule

`default_nettype wire

// File: logic/set_controller.sv
`timescale 1ns/1ns
`default_nettype none

module set_controller
    import fusion_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      go_i,
    input  word_t     input_word_i,
    output addr_t     read_addr_o,
    output logic      cfg_load_o,
    output word_tag_t word_tag_o,
    output logic      run_start_o,
    output logic      finish_o
);

    // State names the address issued in the current cycle
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR0,
        ST_HDR1,
        ST_DATA,
        ST_DONE
    } state_e;

    state_e     state_q;
    addr_t      addr_q;
    logic [7:0] m_q;
    logic [3:0] k_q;
    logic [3:0] word_cnt_q;
    logic [7:0] out_cnt_q;
    logic       hdr1_here_q;
    word_tag_t  tag_q;
    logic [3:0] k_cur;
    logic       last_word;
    logic       last_output;

    // Header 1 is on the bus while the first data address goes out,
    // so K for that first word comes straight from the SRAM
    assign k_cur       = hdr1_here_q ? input_word_i[11:8] : k_q;
    assign last_word   = (word_cnt_q == k_cur - 4'd1);
    assign last_output = (out_cnt_q == m_q - 8'd1);

    assign cfg_load_o  = hdr1_here_q;
    assign run_start_o = (state_q == ST_IDLE) && go_i;
    assign finish_o    = (state_q == ST_DONE);
    assign read_addr_o = addr_q;
    assign word_tag_o  = tag_q;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state_q     <= ST_IDLE;
            addr_q      <= '0;
            m_q         <= '0;
            k_q         <= '0;
            word_cnt_q  <= '0;
            out_cnt_q   <= '0;
            hdr1_here_q <= 1'b0;
            tag_q       <= '0;
        end
        else if (!go_i)
        begin
            state_q     <= ST_IDLE;
            addr_q      <= '0;
            word_cnt_q  <= '0;
            out_cnt_q   <= '0;
            hdr1_here_q <= 1'b0;
            tag_q       <= '0;
        end
        else
        begin
            hdr1_here_q <= 1'b0;
            tag_q.valid <= (state_q == ST_DATA);
            tag_q.last  <= (state_q == ST_DATA) && last_word;
            if (hdr1_here_q)
            begin
                k_q <= input_word_i[11:8];
            end
            case (state_q)
                ST_IDLE:
                begin
                    state_q <= ST_HDR0;
                end
                ST_HDR0:
                begin
                    addr_q  <= addr_q + 1'b1;
                    state_q <= ST_HDR1;
                end
                ST_HDR1:
                begin
                    // Header 0 is present now
                    addr_q <= addr_q + 1'b1;
                    m_q    <= input_word_i[7:0];
                    if (input_word_i[7:0] == END_MARK)
                        state_q <= ST_DONE;
                    else if (input_word_i[7:0] == 8'd0)
                        state_q <= ST_HDR0;
                    else
                    begin
                        state_q     <= ST_DATA;
                        hdr1_here_q <= 1'b1;
                    end
                end
                ST_DATA:
                begin
                    addr_q <= addr_q + 1'b1;
                    if (last_word)
                    begin
                        word_cnt_q <= '0;
                        if (last_output)
                        begin
                            out_cnt_q <= '0;
                            state_q   <= ST_HDR0;
                        end
                        else
                            out_cnt_q <= out_cnt_q + 8'd1;
                    end
                    else
                        word_cnt_q <= word_cnt_q + 4'd1;
                end
                default:
                begin
                    // Done holds until go drops
                    state_q <= ST_DONE;
                end
            endcase
        end
    end

    a_k_nonzero: assert property (@(posedge clock) disable iff (reset)
        cfg_load_o |-> input_word_i[11:8] != 4'd0);

endmodule

`default_nettype wire

// File: logic/fusion_pkg.sv
`default_nettype none

package fusion_pkg;

    localparam int WORD_W     = 16;
    localparam int ADDR_W     = 12;
    localparam int NUM_BRICKS = 8;
    localparam int BRICK_W    = 5;
    localparam int PROD_W     = 16;

    // Output count in header word 0 that ends the program
    localparam logic [7:0] END_MARK = 8'hFF;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // One-hot precision code from header word 1, bits 3:0
    typedef enum logic [3:0] {
        PREC_2 = 4'b0010,
        PREC_4 = 4'b0100,
        PREC_8 = 4'b1000
    } precision_e;

    // Per-brick control
    // The slice is a nibble index, or a 2-bit lane index inside the brick's byte in 2-bit mode
    typedef struct packed {
        logic       enable;
        logic [1:0] in_slice;
        logic       in_signed;
        logic       w_signed;
        logic [1:0] w_slice;
        logic [3:0] shift;
    } brick_ctrl_t;

    typedef struct packed {
        precision_e                        precision;
        brick_ctrl_t [NUM_BRICKS-1:0]      bricks;
    } brick_ctrl_array_t;

    // Travels with each data word down the pipeline
    typedef struct packed {
        logic valid;
        logic last;
    } word_tag_t;

    typedef logic signed [PROD_W-1:0] product_t;
    typedef product_t [NUM_BRICKS-1:0] product_array_t;

endpackage

`default_nettype wire
